// File: design/ring_queue_pkg.sv
package ring_queue_pkg;

   // number of storage slots
   // six is not a power of two, so every pointer needs its wrap logic
   localparam int QUEUE_DEPTH = 6;

   // most words moved on either side in one cycle
   localparam int LANES = 2;

   // payload word width
   localparam int DATA_WIDTH = 16;

   // slot index, enough bits to name slots 0 to QUEUE_DEPTH-1
   localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

   // per-cycle count, 0 to LANES
   localparam int COUNT_WIDTH = $clog2(LANES + 1);

   // occupancy, 0 to QUEUE_DEPTH inclusive
   localparam int OCC_WIDTH = $clog2(QUEUE_DEPTH + 1);

   // the pointer adds at most LANES to an index below QUEUE_DEPTH,
   // so the plain sum still fits PTR_WIDTH bits for this depth
   // and the wrapped sum needs one extra sign bit

endpackage

// File: design/slot_port_if.sv
`timescale 1ns/1ps

// write port from the push side into the slot store
interface slot_write_if
   import ring_queue_pkg::*;
();

   // accepted words this cycle, already clamped to the free space
   logic [COUNT_WIDTH-1:0] wr_count;
   // lane 0 goes to wr_ptr, lane 1 to the slot after it
   logic [PTR_WIDTH-1:0]   wr_ptr;
   logic [DATA_WIDTH-1:0]  wr_data0;
   logic [DATA_WIDTH-1:0]  wr_data1;
   // registered fill level, fed back for the push grant
   logic [OCC_WIDTH-1:0]   occupancy;

   modport producer
   (
      output wr_count,
      output wr_ptr,
      output wr_data0,
      output wr_data1,
      input  occupancy
   );

   modport store
   (
      input  wr_count,
      input  wr_ptr,
      input  wr_data0,
      input  wr_data1,
      output occupancy
   );

endinterface

// read port from the slot store out to the pop side
interface slot_read_if
   import ring_queue_pkg::*;
();

   // granted pops this cycle
   logic [COUNT_WIDTH-1:0] rd_count;
   // oldest slot
   logic [PTR_WIDTH-1:0]   rd_ptr;
   // words at rd_ptr and the slot after it, fall-through
   logic [DATA_WIDTH-1:0]  rd_data0;
   logic [DATA_WIDTH-1:0]  rd_data1;
   logic [OCC_WIDTH-1:0]   occupancy;

   modport consumer
   (
      output rd_count,
      output rd_ptr,
      input  rd_data0,
      input  rd_data1,
      input  occupancy
   );

   modport store
   (
      input  rd_count,
      input  rd_ptr,
      output rd_data0,
      output rd_data1,
      output occupancy
   );

endinterface

// File: design/circular_ptr.sv
`timescale 1ns/1ps

// slot pointer over QUEUE_DEPTH entries
// moves forward by 0 to LANES slots per cycle and wraps past the last slot
module circular_ptr
   import ring_queue_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic [COUNT_WIDTH-1:0] add_i,
   output logic [PTR_WIDTH-1:0]   ptr_o,
   output logic [PTR_WIDTH-1:0]   ptr_next_o
);

   logic [PTR_WIDTH-1:0] ptr_r;
   logic [PTR_WIDTH-1:0] ptr_nowrap;
   // one bit wider, top bit is the sign of the wrapped sum
   logic [PTR_WIDTH:0]   ptr_wrap;

   // both candidates are formed side by side
   // so add_i only goes through one adder before the select

   // plain sum, right while the pointer stays below the depth
   assign ptr_nowrap = ptr_r + PTR_WIDTH'(add_i);

   // sum with the depth taken off
   assign ptr_wrap = {1'b0, ptr_r} + (PTR_WIDTH + 1)'(add_i)
                     - (PTR_WIDTH + 1)'(QUEUE_DEPTH);

   // sign clear means ptr_r + add_i reached QUEUE_DEPTH
   // so take the wrapped value
   assign ptr_next_o = ptr_wrap[PTR_WIDTH] ? ptr_nowrap : ptr_wrap[PTR_WIDTH-1:0];

   // registered pointer, next value lands one edge later
   always_ff @(posedge clk)
   begin
      if (reset_i)
         ptr_r <= '0;
      else
         ptr_r <= ptr_next_o;
   end

   assign ptr_o = ptr_r;

endmodule

// File: design/push_side.sv
`timescale 1ns/1ps

// producer side of the ring queue
// grants as many offered words as there are free slots
// and hands them to the store with the write pointer
module push_side
   import ring_queue_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic [COUNT_WIDTH-1:0] push_count_i,
   input  logic [DATA_WIDTH-1:0]  push_data0_i,
   input  logic [DATA_WIDTH-1:0]  push_data1_i,
   output logic [COUNT_WIDTH-1:0] push_accept_o,
   slot_write_if.producer         wport
);

   // slots not holding a word, 0 to QUEUE_DEPTH
   logic [OCC_WIDTH-1:0]   free_slots;
   // request limited to the lanes that exist
   logic [COUNT_WIDTH-1:0] req_count;

   // free space from the registered occupancy
   // words popped this cycle do not free room until the next edge
   assign free_slots = OCC_WIDTH'(QUEUE_DEPTH) - wport.occupancy;

   // the count port can encode one more than LANES
   // anything above is treated as a full-width offer
   assign req_count = (push_count_i > COUNT_WIDTH'(LANES))
                      ? COUNT_WIDTH'(LANES)
                      : push_count_i;

   // grant is the smaller of request and free space
   // truncation to COUNT_WIDTH only happens when free_slots < req_count
   always_comb
   begin
      if (OCC_WIDTH'(req_count) > free_slots)
         push_accept_o = COUNT_WIDTH'(free_slots);
      else
         push_accept_o = req_count;
   end

   // write pointer, advanced by the same grant that goes to the store
   circular_ptr wr_ptr_inst
   (
      .clk        (clk),
      .reset_i    (reset_i),
      .add_i      (push_accept_o),
      .ptr_o      (wport.wr_ptr),
      .ptr_next_o ()
   );

   // accepted words fill lanes in order
   // lane 0 always first, so a grant of one writes only data0
   assign wport.wr_count = push_accept_o;
   assign wport.wr_data0 = push_data0_i;
   assign wport.wr_data1 = push_data1_i;

   // refused words are simply not written
   // the producer keeps them and may offer again

endmodule

// File: design/slot_store.sv
`timescale 1ns/1ps

// slot registers and occupancy of the ring queue
// two write lanes from the push side, two read lanes to the pop side
module slot_store
   import ring_queue_pkg::*;
(
   input logic         clk,
   input logic         reset_i,
   slot_write_if.store wport,
   slot_read_if.store  rport
);

   // payload slots
   logic [DATA_WIDTH-1:0] slot_r [QUEUE_DEPTH];
   // words held, 0 to QUEUE_DEPTH
   logic [OCC_WIDTH-1:0]  occ_r;
   // second lane positions on each side
   logic [PTR_WIDTH-1:0]  wr_ptr_p1;
   logic [PTR_WIDTH-1:0]  rd_ptr_p1;

   // index of the slot after ptr, wrapping after the last slot
   function automatic logic [PTR_WIDTH-1:0] next_slot(input logic [PTR_WIDTH-1:0] ptr);
      if (ptr == PTR_WIDTH'(QUEUE_DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   assign wr_ptr_p1 = next_slot(wport.wr_ptr);
   assign rd_ptr_p1 = next_slot(rport.rd_ptr);

   // lane 0 writes whenever any word is accepted
   // lane 1 only on a two-word grant
   // the push side never grants into occupied slots, so no overlap with live data
   always_ff @(posedge clk)
   begin
      if (wport.wr_count >= COUNT_WIDTH'(1))
         slot_r[wport.wr_ptr] <= wport.wr_data0;
      if (wport.wr_count >= COUNT_WIDTH'(2))
         slot_r[wr_ptr_p1] <= wport.wr_data1;
   end

   // head words, combinational from the read pointer
   // rd_data1 is only meaningful with two or more words stored
   assign rport.rd_data0 = slot_r[rport.rd_ptr];
   assign rport.rd_data1 = slot_r[rd_ptr_p1];

   // new fill level = old + pushed - popped
   // intermediate sum may wrap in OCC_WIDTH bits, the final value stays in range
   always_ff @(posedge clk)
   begin
      if (reset_i)
         occ_r <= '0;
      else
         occ_r <= occ_r + OCC_WIDTH'(wport.wr_count) - OCC_WIDTH'(rport.rd_count);
   end

   // registered level seen by both sides
   // a word written this cycle is not poppable until the next one
   assign wport.occupancy = occ_r;
   assign rport.occupancy = occ_r;

endmodule

// File: design/pop_side.sv
`timescale 1ns/1ps

// consumer side of the ring queue
// grants pops against the stored words and shows the two oldest words
module pop_side
   import ring_queue_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_i,
   input  logic [COUNT_WIDTH-1:0] pop_count_i,
   output logic [COUNT_WIDTH-1:0] pop_taken_o,
   output logic [DATA_WIDTH-1:0]  pop_data0_o,
   output logic [DATA_WIDTH-1:0]  pop_data1_o,
   output logic [OCC_WIDTH-1:0]   occupancy_o,
   slot_read_if.consumer          rport
);

   // request limited to the lanes that exist
   logic [COUNT_WIDTH-1:0] req_count;

   // counts above LANES ask for both head words
   assign req_count = (pop_count_i > COUNT_WIDTH'(LANES))
                      ? COUNT_WIDTH'(LANES)
                      : pop_count_i;

   // grant is the smaller of request and occupancy
   // occupancy is registered, so a same-cycle push never feeds a pop
   always_comb
   begin
      if (OCC_WIDTH'(req_count) > rport.occupancy)
         pop_taken_o = COUNT_WIDTH'(rport.occupancy);
      else
         pop_taken_o = req_count;
   end

   // read pointer, steps past the popped words at the next edge
   circular_ptr rd_ptr_inst
   (
      .clk        (clk),
      .reset_i    (reset_i),
      .add_i      (pop_taken_o),
      .ptr_o      (rport.rd_ptr),
      .ptr_next_o ()
   );

   // store lowers its occupancy by the same grant
   assign rport.rd_count = pop_taken_o;

   // fall-through head
   // data0 valid with occupancy >= 1, data1 with occupancy >= 2
   assign pop_data0_o = rport.rd_data0;
   assign pop_data1_o = rport.rd_data1;

   // fill level straight from the store register
   assign occupancy_o = rport.occupancy;

endmodule

// File: design/ring_queue.sv
`timescale 1ns/1ps

// six-slot ring queue, up to two words in and two out per cycle
// grants and head words are combinational, storage updates on the edge
module ring_queue
   import ring_queue_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_i,
   // producer
   input  logic [COUNT_WIDTH-1:0] push_count_i,
   input  logic [DATA_WIDTH-1:0]  push_data0_i,
   input  logic [DATA_WIDTH-1:0]  push_data1_i,
   output logic [COUNT_WIDTH-1:0] push_accept_o,
   // consumer
   input  logic [COUNT_WIDTH-1:0] pop_count_i,
   output logic [DATA_WIDTH-1:0]  pop_data0_o,
   output logic [DATA_WIDTH-1:0]  pop_data1_o,
   output logic [COUNT_WIDTH-1:0] pop_taken_o,
   // status
   output logic [OCC_WIDTH-1:0]   occupancy_o
);

   // push side to store
   slot_write_if wr_if ();
   // store to pop side
   slot_read_if  rd_if ();

   // write pointer and push grant
   push_side push_side_inst
   (
      .clk           (clk),
      .reset_i       (reset_i),
      .push_count_i  (push_count_i),
      .push_data0_i  (push_data0_i),
      .push_data1_i  (push_data1_i),
      .push_accept_o (push_accept_o),
      .wport         (wr_if.producer)
   );

   // slots and occupancy
   slot_store slot_store_inst
   (
      .clk     (clk),
      .reset_i (reset_i),
      .wport   (wr_if.store),
      .rport   (rd_if.store)
   );

   // read pointer, pop grant and head words
   pop_side pop_side_inst
   (
      .clk         (clk),
      .reset_i     (reset_i),
      .pop_count_i (pop_count_i),
      .pop_taken_o (pop_taken_o),
      .pop_data0_o (pop_data0_o),
      .pop_data1_o (pop_data1_o),
      .occupancy_o (occupancy_o),
      .rport       (rd_if.consumer)
   );

endmodule

// File: test/ring_queue_assert.sv
`timescale 1ns/1ps

// port rules of the ring queue, bound into every ring_queue instance
module ring_queue_assert
   import ring_queue_pkg::*;
(
   input logic                   clk,
   input logic                   reset_i,
   input logic [COUNT_WIDTH-1:0] push_count_i,
   input logic [COUNT_WIDTH-1:0] push_accept_o,
   input logic [COUNT_WIDTH-1:0] pop_taken_o,
   input logic [OCC_WIDTH-1:0]   occupancy_o
);

   // fill level never above the slot count
   occ_in_range: assert property (@(posedge clk) disable iff (reset_i)
      occupancy_o <= OCC_WIDTH'(QUEUE_DEPTH))
      else $error("occupancy_o above QUEUE_DEPTH");

   // push grant never larger than the offer
   push_within_offer: assert property (@(posedge clk) disable iff (reset_i)
      push_accept_o <= push_count_i)
      else $error("push_accept_o larger than push_count_i");

   // no pop of words that are not stored
   pop_within_occ: assert property (@(posedge clk) disable iff (reset_i)
      OCC_WIDTH'(pop_taken_o) <= occupancy_o)
      else $error("pop_taken_o larger than occupancy_o");

   // queue starts empty right after reset
   empty_after_reset: assert property (@(posedge clk)
      reset_i |=> occupancy_o == '0)
      else $error("occupancy_o not zero after reset");

endmodule

bind ring_queue ring_queue_assert ring_queue_assert_inst
(
   .clk           (clk),
   .reset_i       (reset_i),
   .push_count_i  (push_count_i),
   .push_accept_o (push_accept_o),
   .pop_taken_o   (pop_taken_o),
   .occupancy_o   (occupancy_o)
);

// File: test/ring_queue_tb.sv
`timescale 1ns/1ps

module ring_queue_tb
   import ring_queue_pkg::*;
();

   localparam int CLK_PERIOD = 10;
   localparam int RESET_CYCLES = 10;
   localparam int RAND_CYCLES = 400;
   // directed tests and the drain before the last one
   localparam int DIRECTED_CYCLES = 24;
   localparam int TIMEOUT_NS = (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 50) * CLK_PERIOD;
   // requests per cycle for the fill and for the drain, and the grants they get
   // starting empty on fill and full on drain, both sides see the same sequence
   localparam int STEP_REQ [5] = '{1, 2, 2, 2, 2};
   localparam int STEP_GRANT [5] = '{1, 2, 2, 1, 0};
   localparam logic [DATA_WIDTH-1:0] PROBE_WORD = 16'h5a5a;

   logic                   clk;
   logic                   reset_i;
   logic [COUNT_WIDTH-1:0] push_count_i;
   logic [DATA_WIDTH-1:0]  push_data0_i;
   logic [DATA_WIDTH-1:0]  push_data1_i;
   logic [COUNT_WIDTH-1:0] push_accept_o;
   logic [COUNT_WIDTH-1:0] pop_count_i;
   logic [DATA_WIDTH-1:0]  pop_data0_o;
   logic [DATA_WIDTH-1:0]  pop_data1_o;
   logic [COUNT_WIDTH-1:0] pop_taken_o;
   logic [OCC_WIDTH-1:0]   occupancy_o;

   // reference queue, oldest word at model_head
   logic [DATA_WIDTH-1:0] model_slot [QUEUE_DEPTH];
   int model_head;
   int model_count;

   int error_count;
   int check_count;
   int test_count;
   int test_start_errors;
   int seed;
   // accepted words in push order, for the drain test
   logic [DATA_WIDTH-1:0] expected_words [$];

   ring_queue ring_queue_inst
   (
      .clk           (clk),
      .reset_i       (reset_i),
      .push_count_i  (push_count_i),
      .push_data0_i  (push_data0_i),
      .push_data1_i  (push_data1_i),
      .push_accept_o (push_accept_o),
      .pop_count_i   (pop_count_i),
      .pop_data0_o   (pop_data0_o),
      .pop_data1_o   (pop_data1_o),
      .pop_taken_o   (pop_taken_o),
      .occupancy_o   (occupancy_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // stops a run that never reaches the end of the tests
   initial
   begin
      #(TIMEOUT_NS);
      $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("Checks failed");
      $finish;
   end

   function automatic int smaller(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // expected outputs for this cycle from the model state,
   // then the model takes the same edge as the DUT
   function automatic void model_step(input int push_n, input logic [DATA_WIDTH-1:0] d0,
                                      input logic [DATA_WIDTH-1:0] d1, input int pop_n,
                                      output int exp_push, output int exp_pop,
                                      output logic [DATA_WIDTH-1:0] exp_h0,
                                      output logic [DATA_WIDTH-1:0] exp_h1,
                                      output int exp_occ);
      int tail;
      exp_occ = model_count;
      // push limited by free space, pop by stored words
      exp_push = smaller(push_n, QUEUE_DEPTH - model_count);
      exp_pop = smaller(pop_n, model_count);
      exp_h0 = model_slot[model_head];
      exp_h1 = model_slot[(model_head + 1) % QUEUE_DEPTH];
      tail = (model_head + model_count) % QUEUE_DEPTH;
      if (exp_push >= 1)
         model_slot[tail] = d0;
      if (exp_push >= 2)
         model_slot[(tail + 1) % QUEUE_DEPTH] = d1;
      model_head = (model_head + exp_pop) % QUEUE_DEPTH;
      model_count = model_count + exp_push - exp_pop;
   endfunction

   task automatic check_value(input string label, input int got, input int exp);
      check_count++;
      assert (got == exp)
      else
      begin
         $display("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h", $time, label, got, exp);
         error_count++;
      end
   endtask

   // compare half a cycle before each rising edge, inputs are settled by then
   always @(negedge clk)
   begin
      int exp_push;
      int exp_pop;
      int exp_occ;
      logic [DATA_WIDTH-1:0] exp_h0;
      logic [DATA_WIDTH-1:0] exp_h1;
      if (!reset_i)
      begin
         model_step(int'(push_count_i), push_data0_i, push_data1_i, int'(pop_count_i),
                    exp_push, exp_pop, exp_h0, exp_h1, exp_occ);
         check_value("occupancy_o", int'(occupancy_o), exp_occ);
         check_value("push_accept_o", int'(push_accept_o), exp_push);
         check_value("pop_taken_o", int'(pop_taken_o), exp_pop);
         // head words only hold data with enough words stored
         if (exp_occ >= 1)
            check_value("pop_data0_o", int'(pop_data0_o), int'(exp_h0));
         if (exp_occ >= 2)
            check_value("pop_data1_o", int'(pop_data1_o), int'(exp_h1));
      end
   end

   task automatic apply(input int push_n, input logic [DATA_WIDTH-1:0] d0,
                        input logic [DATA_WIDTH-1:0] d1, input int pop_n);
      push_count_i = COUNT_WIDTH'(push_n);
      push_data0_i = d0;
      push_data1_i = d1;
      pop_count_i = COUNT_WIDTH'(pop_n);
   endtask

   // inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (error_count == test_start_errors)
         $display("test %0d %s: ok", test_count, name);
      else
         $display("test %0d %s: %0d errors", test_count, name, error_count - test_start_errors);
      test_start_errors = error_count;
   endtask

   initial
   begin
      logic [DATA_WIDTH-1:0] w0;
      logic [DATA_WIDTH-1:0] w1;
      int push_n;
      int pop_n;
      seed = 32'hb694_ba83;
      error_count = 0;
      check_count = 0;
      test_count = 0;
      test_start_errors = 0;
      model_head = 0;
      model_count = 0;
      reset_i = 1'b1;
      apply(0, '0, '0, 0);
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset_i = 1'b0;

      // empty queue refuses pops
      for (int i = 0; i < 2; i++)
      begin
         apply(0, '0, '0, LANES);
         @(negedge clk);
         check_value("occupancy_o after reset", int'(occupancy_o), 0);
         check_value("pop_taken_o on empty queue", int'(pop_taken_o), 0);
         next_cycle();
      end
      end_test("reset state");

      // fill, the last offers are clamped to the free space
      for (int i = 0; i < 5; i++)
      begin
         w0 = DATA_WIDTH'(16'h1000 + 2 * i);
         w1 = w0 + 16'h0001;
         apply(STEP_REQ[i], w0, w1, 0);
         @(negedge clk);
         check_value("push_accept_o while filling", int'(push_accept_o), STEP_GRANT[i]);
         if (STEP_GRANT[i] >= 1)
            expected_words.push_back(w0);
         if (STEP_GRANT[i] >= 2)
            expected_words.push_back(w1);
         next_cycle();
      end
      apply(0, '0, '0, 0);
      @(negedge clk);
      check_value("occupancy_o when full", int'(occupancy_o), QUEUE_DEPTH);
      next_cycle();
      end_test("fill to depth");

      // drain in push order, both pointers pass the last slot
      for (int i = 0; i < 5; i++)
      begin
         apply(0, '0, '0, STEP_REQ[i]);
         @(negedge clk);
         check_value("pop_taken_o while draining", int'(pop_taken_o), STEP_GRANT[i]);
         if (expected_words.size() >= 1)
            check_value("pop_data0_o order", int'(pop_data0_o), int'(expected_words[0]));
         if (expected_words.size() >= 2)
            check_value("pop_data1_o order", int'(pop_data1_o), int'(expected_words[1]));
         for (int k = 0; k < STEP_GRANT[i]; k++)
            void'(expected_words.pop_front());
         next_cycle();
      end
      end_test("drain across wrap");

      // random counts on both sides, checked against the model
      for (int i = 0; i < RAND_CYCLES; i++)
      begin
         push_n = int'($unsigned($random(seed)) % (LANES + 1));
         w0 = DATA_WIDTH'($random(seed));
         w1 = DATA_WIDTH'($random(seed));
         pop_n = int'($unsigned($random(seed)) % (LANES + 1));
         apply(push_n, w0, w1, pop_n);
         next_cycle();
      end
      end_test("random traffic");

      // empty the queue, then push one word while popping
      repeat (QUEUE_DEPTH / LANES)
      begin
         apply(0, '0, '0, LANES);
         next_cycle();
      end
      apply(1, PROBE_WORD, '0, LANES);
      @(negedge clk);
      check_value("occupancy_o before probe push", int'(occupancy_o), 0);
      check_value("push_accept_o into empty queue", int'(push_accept_o), 1);
      check_value("pop_taken_o in the push cycle", int'(pop_taken_o), 0);
      next_cycle();
      apply(0, '0, '0, 1);
      @(negedge clk);
      check_value("pop_data0_o after probe push", int'(pop_data0_o), int'(PROBE_WORD));
      check_value("pop_taken_o after probe push", int'(pop_taken_o), 1);
      next_cycle();
      apply(0, '0, '0, 0);
      next_cycle();
      end_test("push then pop timing");

      $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// File: ring_queue.f
design/ring_queue_pkg.sv
design/slot_port_if.sv
design/circular_ptr.sv
design/push_side.sv
design/slot_store.sv
design/pop_side.sv
design/ring_queue.sv
test/ring_queue_assert.sv
test/ring_queue_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ring queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module ring_queue_tb \
   -f ring_queue.f \
   -o ring_queue_sim

# an assertion stop gives a non-zero exit, the verdict still comes from the output
sim_out=$(./obj_dir/ring_queue_sim 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "All checks passed"; then
   exit 0
fi

echo "simulation did not report a pass"
exit 1
